// ==== files.f ====
source/load_unit_pkg.sv
source/load_buffer_slot.sv
source/load_request_ctrl.sv
source/load_result_align.sv
source/load_unit.sv
testbench/tb_load_unit.sv

// ==== Makefile ====
TOOL     := verilator
TOP      := tb_load_unit
FILELIST := files.f
FLAGS    := --binary --timing --assert
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_load_unit.sv ====
module tb_load_unit;

  // upper bound on the test length with a fivefold margin
  localparam int TEST_CYCLES = 400;
  localparam int MAX_CYCLES  = 5 * TEST_CYCLES;
  localparam int NR_ENTRIES  = 4;
  // physical address bits the MMU model puts above the virtual address
  localparam logic [16:0] PA_HIGH = 17'h000a5;

  logic clk;
  logic rst_n;
  logic flush;
  logic valid;
  logic [load_unit_pkg::VLEN-1:0] vaddr;
  load_unit_pkg::ld_op_e op;
  logic [load_unit_pkg::BE_BITS-1:0] be;
  logic [load_unit_pkg::TRANS_ID_BITS-1:0] trans_id;
  logic pop_ld_o;
  logic translation_req_o;
  logic [load_unit_pkg::PLEN-1:0] paddr;
  logic dtlb_hit;
  logic page_offset_matches;
  logic data_req_o;
  logic [load_unit_pkg::DCACHE_INDEX_WIDTH-1:0] address_index_o;
  logic [load_unit_pkg::DCACHE_TAG_WIDTH-1:0] address_tag_o;
  logic [load_unit_pkg::DCACHE_ID_BITS-1:0] data_id_o;
  logic [load_unit_pkg::BE_BITS-1:0] data_be_o;
  logic [1:0] data_size_o;
  logic tag_valid_o;
  logic kill_req_o;
  logic data_gnt;
  logic data_rvalid;
  logic [load_unit_pkg::DCACHE_ID_BITS-1:0] data_rid;
  logic [load_unit_pkg::XLEN-1:0] data_rdata;
  logic valid_o;
  logic [load_unit_pkg::TRANS_ID_BITS-1:0] trans_id_o;
  logic [load_unit_pkg::XLEN-1:0] result_o;

  integer seed;
  int cycles;
  int pop_cnt;
  logic prev_pop;
  logic [load_unit_pkg::TRANS_ID_BITS-1:0] tid_cnt;
  logic [load_unit_pkg::DCACHE_TAG_WIDTH-1:0] exp_tag;
  // buffer slots the testbench knows to be outstanding
  logic [NR_ENTRIES-1:0] busy;

  // memory model with one word per index line
  logic [63:0] mem [16];
  // what each outstanding cache id is expected to return
  logic [63:0] pend_word [8];
  logic [2:0] pend_off [8];
  logic [2:0] pend_tid [8];
  load_unit_pkg::ld_op_e pend_op [8];

  // MMU model puts fixed upper bits in front of the virtual address
  assign paddr = {PA_HIGH, vaddr};

  load_unit #(
    .NR_LDBUF_ENTRIES (NR_ENTRIES)
  ) u_dut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .flush_i               (flush),
    .valid_i               (valid),
    .vaddr_i               (vaddr),
    .op_i                  (op),
    .be_i                  (be),
    .trans_id_i            (trans_id),
    .pop_ld_o              (pop_ld_o),
    .translation_req_o     (translation_req_o),
    .paddr_i               (paddr),
    .dtlb_hit_i            (dtlb_hit),
    .page_offset_matches_i (page_offset_matches),
    .data_req_o            (data_req_o),
    .address_index_o       (address_index_o),
    .address_tag_o         (address_tag_o),
    .data_id_o             (data_id_o),
    .data_be_o             (data_be_o),
    .data_size_o           (data_size_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .data_gnt_i            (data_gnt),
    .data_rvalid_i         (data_rvalid),
    .data_rid_i            (data_rid),
    .data_rdata_i          (data_rdata),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .result_o              (result_o)
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // reference rules and checking
  // ----------------------------------------------------------------------
  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic int size_bytes(input load_unit_pkg::ld_op_e o);
    case (o)
      load_unit_pkg::LD:                     return 8;
      load_unit_pkg::LW, load_unit_pkg::LWU: return 4;
      load_unit_pkg::LH, load_unit_pkg::LHU: return 2;
      default:                               return 1;
    endcase
  endfunction

  // bytes from the offset upward and then sign or zero fill byte by byte
  function automatic logic [63:0] expected_result(input logic [63:0] word,
                                                  input logic [2:0] off,
                                                  input load_unit_pkg::ld_op_e o);
    logic [63:0] res;
    logic sext;
    int n;
    n = size_bytes(o);
    sext = (o == load_unit_pkg::LW) || (o == load_unit_pkg::LH) || (o == load_unit_pkg::LB);
    res = '0;
    for (int b = 0; b < 8; b++) begin
      if (b < n) begin
        res[8*b +: 8] = word[8*(int'(off) + b) +: 8];
      end else begin
        res[8*b +: 8] = {8{sext & res[8*n-1]}};
      end
    end
    return res;
  endfunction

  // first slot from the bottom that is not outstanding
  function automatic logic [2:0] lowest_free(input logic [NR_ENTRIES-1:0] used);
    logic [2:0] idx;
    logic found;
    idx = '0;
    found = 1'b0;
    for (int i = 0; i < NR_ENTRIES; i++) begin
      if (!found && !used[i]) begin
        idx = 3'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic logic [38:0] make_addr(input logic [3:0] word_idx, input logic [2:0] off);
    return {27'h0012345, 5'd0, word_idx, off};
  endfunction

  // watches tag timing, tag value and request fields
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_pop) begin
        check(64'(tag_valid_o), 64'd1, "tag_valid_o one cycle after pop");
      end
      if (tag_valid_o && !kill_req_o) begin
        check(64'(prev_pop), 64'd1, "tag_valid_o without a pop one cycle before");
        check(64'(address_tag_o), 64'(exp_tag), "address_tag_o");
      end
      if (data_req_o && data_gnt) begin
        check(64'(data_size_o), 64'($clog2(size_bytes(op))), "data_size_o");
        check(64'(data_be_o), 64'(be), "data_be_o");
        // index is the untranslated page offset
        check(64'(address_index_o), 64'(vaddr[11:0]), "address_index_o");
      end
      if (pop_ld_o) begin
        // tag is the physical address above the page offset
        exp_tag = {PA_HIGH, vaddr[load_unit_pkg::VLEN-1:12]};
        pop_cnt = pop_cnt + 1;
      end
      prev_pop = pop_ld_o;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("Testbench failed");
      $fatal(1, "run limit reached");
    end
  end

  // ----------------------------------------------------------------------
  // stimulus helpers start and end 1 unit after a rising edge
  // ----------------------------------------------------------------------
  task automatic drive_request(input load_unit_pkg::ld_op_e o, input logic [38:0] va);
    logic [31:0] rnd;
    rnd = $random(seed);
    valid = 1'b1;
    vaddr = va;
    op = o;
    be = rnd[7:0];
    trans_id = tid_cnt;
    tid_cnt = tid_cnt + 3'd1;
  endtask

  task automatic wait_pop(output logic [2:0] id);
    @(negedge clk);
    while (!pop_ld_o) @(negedge clk);
    id = data_id_o;
    // the lowest free slot is allocated
    check(64'(id), 64'(lowest_free(busy)), "data_id_o");
    busy[id] = 1'b1;
    pend_tid[id] = trans_id;
    pend_op[id] = op;
    pend_off[id] = vaddr[2:0];
    pend_word[id] = mem[vaddr[6:3]];
    @(posedge clk);
    #1;
    valid = 1'b0;
  endtask

  task automatic issue_load(input load_unit_pkg::ld_op_e o, input logic [38:0] va,
                            output logic [2:0] id);
    drive_request(o, va);
    wait_pop(id);
  endtask

  // cache response for one id with the result checked in the same cycle
  task automatic respond(input logic [2:0] id, input logic exp_valid);
    busy[id] = 1'b0;
    data_rvalid = 1'b1;
    data_rid = id;
    data_rdata = pend_word[id];
    @(negedge clk);
    check(64'(valid_o), 64'(exp_valid), "valid_o");
    if (exp_valid) begin
      check(64'(trans_id_o), 64'(pend_tid[id]), "trans_id_o");
      check(result_o, expected_result(pend_word[id], pend_off[id], pend_op[id]), "result_o");
    end
    @(posedge clk);
    #1;
    data_rvalid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic reset_outputs_low();
    @(negedge clk);
    check(64'(data_req_o), 64'd0, "data_req_o after reset");
    check(64'(tag_valid_o), 64'd0, "tag_valid_o after reset");
    check(64'(kill_req_o), 64'd0, "kill_req_o after reset");
    check(64'(pop_ld_o), 64'd0, "pop_ld_o after reset");
    check(64'(translation_req_o), 64'd0, "translation_req_o after reset");
    check(64'(valid_o), 64'd0, "valid_o after reset");
    @(posedge clk);
    #1;
  endtask

  // every op at every aligned offset
  task automatic all_load_types();
    logic [2:0] id;
    logic [31:0] rnd;
    load_unit_pkg::ld_op_e o;
    int n;
    for (int k = 0; k < 7; k++) begin
      o = load_unit_pkg::ld_op_e'(3'(k));
      n = size_bytes(o);
      for (int off = 0; off < 8; off += n) begin
        rnd = $random(seed);
        issue_load(o, make_addr(rnd[3:0], 3'(off)), id);
        respond(id, 1'b1);
      end
    end
  endtask

  task automatic delayed_grant();
    logic [2:0] id;
    data_gnt = 1'b0;
    drive_request(load_unit_pkg::LH, make_addr(4'd5, 3'd2));
    repeat (3) begin
      @(negedge clk);
      check(64'(data_req_o), 64'd1, "data_req_o while grant is held back");
      check(64'(pop_ld_o), 64'd0, "pop_ld_o before grant");
      @(posedge clk);
      #1;
    end
    data_gnt = 1'b1;
    wait_pop(id);
    respond(id, 1'b1);
  endtask

  // four outstanding loads block a fifth and get answers in reverse order
  task automatic full_buffer_reverse();
    logic [2:0] ids [4];
    logic [2:0] fifth;
    for (int i = 0; i < 4; i++) begin
      issue_load(load_unit_pkg::LW, make_addr(4'(i + 8), 3'd4), ids[i]);
    end
    drive_request(load_unit_pkg::LBU, make_addr(4'd3, 3'd7));
    repeat (3) begin
      @(negedge clk);
      check(64'(pop_ld_o), 64'd0, "pop_ld_o with full buffer");
      check(64'(data_req_o), 64'd0, "data_req_o with full buffer");
      @(posedge clk);
      #1;
    end
    respond(ids[3], 1'b1);
    wait_pop(fifth);
    for (int i = 2; i >= 0; i--) begin
      respond(ids[i], 1'b1);
    end
    respond(fifth, 1'b1);
  endtask

  task automatic store_offset_stall();
    logic [2:0] id;
    int pops;
    pops = pop_cnt;
    page_offset_matches = 1'b1;
    drive_request(load_unit_pkg::LB, make_addr(4'd9, 3'd3));
    repeat (4) begin
      @(negedge clk);
      check(64'(data_req_o), 64'd0, "data_req_o during store match");
      @(posedge clk);
      #1;
    end
    page_offset_matches = 1'b0;
    wait_pop(id);
    respond(id, 1'b1);
    idle_cycles(3);
    check(64'(pop_cnt), 64'(pops + 1), "pop count after store stall");
  endtask

  task automatic translation_miss();
    logic [2:0] id;
    int pops;
    pops = pop_cnt;
    dtlb_hit = 1'b0;
    drive_request(load_unit_pkg::LD, make_addr(4'd12, 3'd0));
    @(negedge clk);
    check(64'(pop_ld_o), 64'd0, "pop_ld_o on translation miss");
    id = data_id_o;
    // the aborted grant still takes the lowest free slot
    check(64'(id), 64'(lowest_free(busy)), "data_id_o on aborted grant");
    @(posedge clk);
    #1;
    // killed request is answered right away
    data_rvalid = 1'b1;
    data_rid = id;
    data_rdata = '1;
    @(negedge clk);
    check(64'(kill_req_o), 64'd1, "kill_req_o after miss");
    check(64'(tag_valid_o), 64'd1, "tag_valid_o after miss");
    check(64'(valid_o), 64'd0, "valid_o for killed request");
    @(posedge clk);
    #1;
    data_rvalid = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check(64'(translation_req_o), 64'd1, "translation_req_o during walk");
      check(64'(data_req_o), 64'd0, "data_req_o during walk");
      @(posedge clk);
      #1;
    end
    dtlb_hit = 1'b1;
    wait_pop(id);
    respond(id, 1'b1);
    idle_cycles(3);
    check(64'(pop_cnt), 64'(pops + 1), "pop count after miss");
  endtask

  task automatic flush_drops_loads();
    logic [2:0] id0;
    logic [2:0] id1;
    logic [2:0] id2;
    issue_load(load_unit_pkg::LHU, make_addr(4'd1, 3'd6), id0);
    issue_load(load_unit_pkg::LWU, make_addr(4'd2, 3'd0), id1);
    idle_cycles(1);
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(negedge clk);
    check(64'(kill_req_o), 64'd1, "kill_req_o after flush");
    check(64'(tag_valid_o), 64'd1, "tag_valid_o after flush");
    @(posedge clk);
    #1;
    respond(id1, 1'b0);
    respond(id0, 1'b0);
    issue_load(load_unit_pkg::LB, make_addr(4'd7, 3'd5), id2);
    respond(id2, 1'b1);
  endtask

  initial begin
    seed = 32'h67c9_787c;
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    valid = 1'b0;
    vaddr = '0;
    op = load_unit_pkg::LD;
    be = '0;
    trans_id = '0;
    dtlb_hit = 1'b1;
    page_offset_matches = 1'b0;
    data_gnt = 1'b1;
    data_rvalid = 1'b0;
    data_rid = '0;
    data_rdata = '0;
    tid_cnt = '0;
    exp_tag = '0;
    busy = '0;
    prev_pop = 1'b0;
    pop_cnt = 0;
    cycles = 0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = {$random(seed), $random(seed)};
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_outputs_low();
    all_load_types();
    delayed_grant();
    full_buffer_reverse();
    store_offset_stall();
    translation_miss();
    flush_drops_loads();
    idle_cycles(2);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== source/load_unit.sv ====
module load_unit #(
  parameter int unsigned NR_LDBUF_ENTRIES = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  // request in
  input  logic                                         valid_i,
  input  logic [load_unit_pkg::VLEN-1:0]               vaddr_i,
  input  load_unit_pkg::ld_op_e                        op_i,
  input  logic [load_unit_pkg::BE_BITS-1:0]            be_i,
  input  logic [load_unit_pkg::TRANS_ID_BITS-1:0]      trans_id_i,
  output logic                                         pop_ld_o,
  // translation
  output logic                                         translation_req_o,
  input  logic [load_unit_pkg::PLEN-1:0]               paddr_i,
  input  logic                                         dtlb_hit_i,
  // store check
  input  logic                                         page_offset_matches_i,
  // cache request
  output logic                                         data_req_o,
  output logic [load_unit_pkg::DCACHE_INDEX_WIDTH-1:0] address_index_o,
  output logic [load_unit_pkg::DCACHE_TAG_WIDTH-1:0]   address_tag_o,
  output logic [load_unit_pkg::DCACHE_ID_BITS-1:0]     data_id_o,
  output logic [load_unit_pkg::BE_BITS-1:0]            data_be_o,
  output logic [1:0]                                   data_size_o,
  output logic                                         tag_valid_o,
  output logic                                         kill_req_o,
  input  logic                                         data_gnt_i,
  // cache response
  input  logic                                         data_rvalid_i,
  input  logic [load_unit_pkg::DCACHE_ID_BITS-1:0]     data_rid_i,
  input  logic [load_unit_pkg::XLEN-1:0]               data_rdata_i,
  // result
  output logic                                         valid_o,
  output logic [load_unit_pkg::TRANS_ID_BITS-1:0]      trans_id_o,
  output logic [load_unit_pkg::XLEN-1:0]               result_o
);

  localparam int unsigned ID_W = $clog2(NR_LDBUF_ENTRIES);

  // slot flags and fields
  logic [NR_LDBUF_ENTRIES-1:0] slot_valid;
  logic [NR_LDBUF_ENTRIES-1:0] slot_flushed;
  logic [NR_LDBUF_ENTRIES-1:0] slot_we;
  logic [NR_LDBUF_ENTRIES-1:0] slot_free;
  logic [NR_LDBUF_ENTRIES-1:0][load_unit_pkg::TRANS_ID_BITS-1:0] slot_trans_id;
  logic [NR_LDBUF_ENTRIES-1:0][load_unit_pkg::ALIGN_BITS-1:0]    slot_offset;
  load_unit_pkg::ld_op_e [NR_LDBUF_ENTRIES-1:0] slot_op;

  // entry being written on grant
  logic [load_unit_pkg::TRANS_ID_BITS-1:0] entry_trans_id;
  logic [load_unit_pkg::ALIGN_BITS-1:0]    entry_offset;
  load_unit_pkg::ld_op_e                   entry_op;
  logic [ID_W-1:0]                         last_id;

  // --------------------------------------------------------------------
  // request side
  // --------------------------------------------------------------------
  load_request_ctrl #(
    .NR_LDBUF_ENTRIES (NR_LDBUF_ENTRIES)
  ) u_req_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .vaddr_i               (vaddr_i),
    .op_i                  (op_i),
    .be_i                  (be_i),
    .trans_id_i            (trans_id_i),
    .pop_ld_o              (pop_ld_o),
    .translation_req_o     (translation_req_o),
    .paddr_i               (paddr_i),
    .dtlb_hit_i            (dtlb_hit_i),
    .page_offset_matches_i (page_offset_matches_i),
    .data_req_o            (data_req_o),
    .address_index_o       (address_index_o),
    .address_tag_o         (address_tag_o),
    .data_id_o             (data_id_o),
    .data_be_o             (data_be_o),
    .data_size_o           (data_size_o),
    .tag_valid_o           (tag_valid_o),
    .kill_req_o            (kill_req_o),
    .data_gnt_i            (data_gnt_i),
    .slot_valid_i          (slot_valid),
    .slot_we_o             (slot_we),
    .entry_trans_id_o      (entry_trans_id),
    .entry_offset_o        (entry_offset),
    .entry_op_o            (entry_op),
    .last_id_o             (last_id)
  );

  // one slot per outstanding load
  for (genvar i = 0; i < NR_LDBUF_ENTRIES; i++) begin : gen_ldbuf
    load_buffer_slot u_slot (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .flush_i    (flush_i),
      .we_i       (slot_we[i]),
      .free_i     (slot_free[i]),
      .trans_id_i (entry_trans_id),
      .offset_i   (entry_offset),
      .op_i       (entry_op),
      .valid_o    (slot_valid[i]),
      .flushed_o  (slot_flushed[i]),
      .trans_id_o (slot_trans_id[i]),
      .offset_o   (slot_offset[i]),
      .op_o       (slot_op[i])
    );
  end

  // --------------------------------------------------------------------
  // response side
  // --------------------------------------------------------------------
  load_result_align #(
    .NR_LDBUF_ENTRIES (NR_LDBUF_ENTRIES)
  ) u_align (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .data_rvalid_i   (data_rvalid_i),
    .data_rid_i      (data_rid_i),
    .data_rdata_i    (data_rdata_i),
    .slot_valid_i    (slot_valid),
    .slot_flushed_i  (slot_flushed),
    .slot_trans_id_i (slot_trans_id),
    .slot_offset_i   (slot_offset),
    .slot_op_i       (slot_op),
    .slot_free_o     (slot_free),
    .last_id_i       (last_id),
    .kill_req_i      (kill_req_o),
    .valid_o         (valid_o),
    .trans_id_o      (trans_id_o),
    .result_o        (result_o)
  );

endmodule

// ==== source/load_result_align.sv ====
module load_result_align #(
  parameter int unsigned NR_LDBUF_ENTRIES = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // cache response, no back-pressure
  input  logic                                   data_rvalid_i,
  input  logic [load_unit_pkg::DCACHE_ID_BITS-1:0] data_rid_i,
  input  logic [load_unit_pkg::XLEN-1:0]         data_rdata_i,
  // all slots
  input  logic [NR_LDBUF_ENTRIES-1:0]            slot_valid_i,
  input  logic [NR_LDBUF_ENTRIES-1:0]            slot_flushed_i,
  input  logic [NR_LDBUF_ENTRIES-1:0][load_unit_pkg::TRANS_ID_BITS-1:0] slot_trans_id_i,
  input  logic [NR_LDBUF_ENTRIES-1:0][load_unit_pkg::ALIGN_BITS-1:0]    slot_offset_i,
  input  load_unit_pkg::ld_op_e [NR_LDBUF_ENTRIES-1:0] slot_op_i,
  output logic [NR_LDBUF_ENTRIES-1:0]            slot_free_o,
  // tag cycle state from the controller
  input  logic [$clog2(NR_LDBUF_ENTRIES)-1:0]    last_id_i,
  input  logic                                   kill_req_i,
  // result toward writeback
  output logic                                   valid_o,
  output logic [load_unit_pkg::TRANS_ID_BITS-1:0] trans_id_o,
  output logic [load_unit_pkg::XLEN-1:0]         result_o
);

  localparam int unsigned ID_W = $clog2(NR_LDBUF_ENTRIES);

  logic [ID_W-1:0] rid;
  load_unit_pkg::ld_op_e rd_op;
  logic [load_unit_pkg::XLEN-1:0] shifted;
  logic is_signed;
  logic fill_bit;

  // --------------------------------------------------------------------
  // slot read and release
  // --------------------------------------------------------------------
  assign rid   = data_rid_i[ID_W-1:0];
  assign rd_op = slot_op_i[rid];

  always_comb begin
    slot_free_o = '0;
    if (data_rvalid_i) begin
      slot_free_o[rid] = 1'b1;
    end
  end

  assign trans_id_o = slot_trans_id_i[rid];

  // drop flushed loads and the one being killed right now
  assign valid_o = data_rvalid_i & ~slot_flushed_i[rid]
                 & ~(kill_req_i & (last_id_i == rid));

  // --------------------------------------------------------------------
  // realign and extend
  // --------------------------------------------------------------------
  // addressed byte moves down to bit 0
  assign shifted = data_rdata_i >> {slot_offset_i[rid], 3'b000};

  assign is_signed = rd_op inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};

  // top bit of the loaded field, zero for unsigned ops
  always_comb begin
    case (rd_op)
      load_unit_pkg::LW: fill_bit = shifted[31];
      load_unit_pkg::LH: fill_bit = shifted[15];
      default:           fill_bit = shifted[7];
    endcase
    fill_bit = fill_bit & is_signed;
  end

  always_comb begin
    case (rd_op)
      load_unit_pkg::LW, load_unit_pkg::LWU: result_o = {{32{fill_bit}}, shifted[31:0]};
      load_unit_pkg::LH, load_unit_pkg::LHU: result_o = {{48{fill_bit}}, shifted[15:0]};
      load_unit_pkg::LB, load_unit_pkg::LBU: result_o = {{56{fill_bit}}, shifted[7:0]};
      // full double word
      default:                               result_o = shifted;
    endcase
  end

  // cache answers only requests it granted
  a_rid_names_valid_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) data_rvalid_i |-> slot_valid_i[rid]
  ) else $error("cache response for a load buffer slot that is not outstanding");

endmodule

// ==== source/load_request_ctrl.sv ====
module load_request_ctrl #(
  parameter int unsigned NR_LDBUF_ENTRIES = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  // request from the issue side
  input  logic                                         valid_i,
  input  logic [load_unit_pkg::VLEN-1:0]               vaddr_i,
  input  load_unit_pkg::ld_op_e                        op_i,
  input  logic [load_unit_pkg::BE_BITS-1:0]            be_i,
  input  logic [load_unit_pkg::TRANS_ID_BITS-1:0]      trans_id_i,
  output logic                                         pop_ld_o,
  // translation
  output logic                                         translation_req_o,
  input  logic [load_unit_pkg::PLEN-1:0]               paddr_i,
  input  logic                                         dtlb_hit_i,
  // pending store check
  input  logic                                         page_offset_matches_i,
  // cache request
  output logic                                         data_req_o,
  output logic [load_unit_pkg::DCACHE_INDEX_WIDTH-1:0] address_index_o,
  output logic [load_unit_pkg::DCACHE_TAG_WIDTH-1:0]   address_tag_o,
  output logic [load_unit_pkg::DCACHE_ID_BITS-1:0]     data_id_o,
  output logic [load_unit_pkg::BE_BITS-1:0]            data_be_o,
  output logic [1:0]                                   data_size_o,
  output logic                                         tag_valid_o,
  output logic                                         kill_req_o,
  input  logic                                         data_gnt_i,
  // load buffer slots
  input  logic [NR_LDBUF_ENTRIES-1:0]                  slot_valid_i,
  output logic [NR_LDBUF_ENTRIES-1:0]                  slot_we_o,
  output logic [load_unit_pkg::TRANS_ID_BITS-1:0]      entry_trans_id_o,
  output logic [load_unit_pkg::ALIGN_BITS-1:0]         entry_offset_o,
  output load_unit_pkg::ld_op_e                        entry_op_o,
  // slot of the most recent grant, for the aligner
  output logic [$clog2(NR_LDBUF_ENTRIES)-1:0]          last_id_o
);

  localparam int unsigned ID_W = $clog2(NR_LDBUF_ENTRIES);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    ABORT_TRANSACTION,
    WAIT_TRANSLATION,
    WAIT_FLUSH
  } state_e;

  state_e state_q, state_d;

  logic [ID_W-1:0] free_idx;
  logic buf_full;
  logic accept_req;
  logic grant;
  logic [load_unit_pkg::DCACHE_TAG_WIDTH-1:0] tag_q;

  // --------------------------------------------------------------------
  // free slot search
  // --------------------------------------------------------------------
  assign buf_full = &slot_valid_i;

  // lowest invalid slot wins, scan from the top down
  always_comb begin
    free_idx = '0;
    for (int i = NR_LDBUF_ENTRIES - 1; i >= 0; i--) begin
      if (!slot_valid_i[i]) begin
        free_idx = ID_W'(i);
      end
    end
  end

  // every grant allocates a slot, even one that is aborted later
  assign grant = data_req_o & data_gnt_i;

  always_comb begin
    slot_we_o = '0;
    if (grant) begin
      slot_we_o[free_idx] = 1'b1;
    end
  end

  // entry payload straight from the request
  assign entry_trans_id_o = trans_id_i;
  assign entry_offset_o   = vaddr_i[load_unit_pkg::ALIGN_BITS-1:0];
  assign entry_op_o       = op_i;

  // cache sees the slot index as request id
  always_comb begin
    data_id_o = '0;
    data_id_o[ID_W-1:0] = free_idx;
  end

  // index goes out first, untranslated
  assign address_index_o = vaddr_i[load_unit_pkg::DCACHE_INDEX_WIDTH-1:0];
  assign data_be_o       = be_i;
  assign data_size_o     = load_unit_pkg::transfer_size(op_i);
  // tag captured at grant, sent in the following cycle
  assign address_tag_o   = tag_q;

  // --------------------------------------------------------------------
  // request FSM
  // --------------------------------------------------------------------
  assign accept_req = valid_i & ~buf_full;

  always_comb begin
    state_d           = state_q;
    translation_req_o = 1'b0;
    data_req_o        = 1'b0;
    tag_valid_o       = 1'b0;
    kill_req_o        = 1'b0;
    pop_ld_o          = 1'b0;

    case (state_q)
      // SEND_TAG finishes the previous load and may start the next one
      IDLE, SEND_TAG: begin
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept_req) begin
          // translate early, even if a store blocks the offset
          translation_req_o = 1'b1;
          if (page_offset_matches_i) begin
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (!data_gnt_i) begin
              state_d = WAIT_GNT;
            end else if (!dtlb_hit_i) begin
              state_d = ABORT_TRANSACTION;
            end else begin
              state_d  = SEND_TAG;
              pop_ld_o = 1'b1;
            end
          end
        end
      end
      // a store to the same page offset is still pending
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        translation_req_o = 1'b1;
        data_req_o        = 1'b1;
        if (data_gnt_i) begin
          if (!dtlb_hit_i) begin
            state_d = ABORT_TRANSACTION;
          end else begin
            state_d  = SEND_TAG;
            pop_ld_o = 1'b1;
          end
        end
      end
      // tlb missed after grant, drop the cache request
      ABORT_TRANSACTION: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = WAIT_TRANSLATION;
      end
      // hold the translation request until the walk is done
      WAIT_TRANSLATION: begin
        translation_req_o = 1'b1;
        if (dtlb_hit_i) begin
          state_d = WAIT_GNT;
        end
      end
      // kill whatever tag cycle was due
      WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      last_id_o <= '0;
    end else begin
      state_q <= state_d;
      if (grant) begin
        last_id_o <= free_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      tag_q <= paddr_i[load_unit_pkg::PLEN-1:load_unit_pkg::DCACHE_INDEX_WIDTH];
    end
  end

  // a cache grant must never find the load buffer full
  a_no_grant_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) grant |-> !buf_full
  ) else $error("cache grant taken with every load buffer slot valid");

endmodule

// ==== source/load_buffer_slot.sv ====
module load_buffer_slot (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    flush_i,
  input  logic                                    we_i,
  input  logic                                    free_i,
  input  logic [load_unit_pkg::TRANS_ID_BITS-1:0] trans_id_i,
  input  logic [load_unit_pkg::ALIGN_BITS-1:0]    offset_i,
  input  load_unit_pkg::ld_op_e                   op_i,
  output logic                                    valid_o,
  output logic                                    flushed_o,
  output logic [load_unit_pkg::TRANS_ID_BITS-1:0] trans_id_o,
  output logic [load_unit_pkg::ALIGN_BITS-1:0]    offset_o,
  output load_unit_pkg::ld_op_e                   op_o
);

  // --------------------------------------------------------------------
  // entry flags
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o   <= 1'b0;
      flushed_o <= 1'b0;
    end else begin
      // a new load wins over free and flush
      if (we_i) begin
        valid_o   <= 1'b1;
        flushed_o <= 1'b0;
      end else begin
        if (free_i) begin
          valid_o <= 1'b0;
        end
        // response still comes back, but is dropped
        if (flush_i) begin
          flushed_o <= 1'b1;
        end
      end
    end
  end

  // payload of the outstanding load
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      trans_id_o <= trans_id_i;
      offset_o   <= offset_i;
      op_o       <= op_i;
    end
  end

  // the controller only allocates free slots
  a_write_free_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) we_i |-> !valid_o
  ) else $error("load buffer slot overwritten while outstanding");

endmodule

// ==== source/load_unit_pkg.sv ====
package load_unit_pkg;

  // --------------------------------------------------------------------
  // core and cache widths
  // --------------------------------------------------------------------
  localparam int unsigned XLEN = 64;
  localparam int unsigned VLEN = 39;
  localparam int unsigned PLEN = 56;
  // scoreboard id of the issuing instruction
  localparam int unsigned TRANS_ID_BITS = 3;
  // byte offset inside one 64 bit word
  localparam int unsigned ALIGN_BITS = 3;
  localparam int unsigned BE_BITS = 8;
  // index is the untranslated page offset
  localparam int unsigned DCACHE_INDEX_WIDTH = 12;
  localparam int unsigned DCACHE_TAG_WIDTH = PLEN - DCACHE_INDEX_WIDTH;
  // request id toward the cache, caps the load buffer at 8 entries
  localparam int unsigned DCACHE_ID_BITS = 3;

  // supported load operations
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_e;

  // cache size code, byte 0 up to double 3
  function automatic logic [1:0] transfer_size(ld_op_e op);
    case (op)
      LD:       return 2'b11;
      LW, LWU:  return 2'b10;
      LH, LHU:  return 2'b01;
      default:  return 2'b00;
    endcase
  endfunction

endpackage
